// File: common/usb_crc_pkg.sv
/*
 * USB CRC subsystem package
 *
 * Holds the FIFO entry, packet length and CRC16 types, plus the
 * constants of the USB data CRC (reflected 0x8005, seed all ones).
 */

package usb_crc_pkg;

	// ----------------------------------------
	// Types
	// ----------------------------------------

	// One buffered byte, last marks the end of a packet
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} usb_byte_t;

	// Packet byte count, 1 to 1023
	typedef logic [9:0] usb_len_t;

	typedef logic [15:0] usb_crc_t;

	// ----------------------------------------
	// CRC16 constants
	// ----------------------------------------

	// 0x8005 bit-reversed, for LSB-first shifting
	localparam usb_crc_t CRC_POLY_REFL = 16'hA001;
	localparam usb_crc_t CRC_INIT      = 16'hFFFF;

endpackage

// File: verilog/usb_rst_seq.sv
/*
 * USB domain reset sequencer
 *
 * Holds rst_usb while the PLL is unlocked, then keeps it asserted
 * for eight more clk_usb cycles before a synchronous release.
 */

`timescale 1ns/1ns

module usb_rst_seq (
	input  logic clk_usb,
	input  logic pll_lock,
	output logic rst_usb
);

	// Counter top bit doubles as the reset
	logic [3:0] rst_cnt;

	// ----------------------------------------
	// Release counter
	// ----------------------------------------

	// Loaded with 8 while unlocked, wraps to 0 after eight edges
	always_ff @(posedge clk_usb or negedge pll_lock) begin
		if (!pll_lock) begin
			rst_cnt <= 4'd8;
		end else if (rst_cnt[3]) begin
			rst_cnt <= rst_cnt + 4'd1;
		end
	end

	assign rst_usb = rst_cnt[3];

endmodule

// File: verilog/usb_byte_rx.sv
/*
 * Packet byte receiver
 *
 * Four-phase req/ack slave on the input channel. Each accepted byte
 * is pushed into the FIFO in the cycle in_ack rises; the acknowledge
 * is withheld while the FIFO is full.
 */

`timescale 1ns/1ns

module usb_byte_rx (
	input  logic                  clk_usb,
	input  logic                  rst_usb,
	input  logic                  in_req,
	input  logic [7:0]            in_data,
	input  logic                  in_last,
	output logic                  in_ack,
	input  logic                  full,
	output logic                  wr_en,
	output usb_crc_pkg::usb_byte_t wr_byte
);

	typedef enum logic {
		RX_IDLE,
		RX_ACK
	} rx_state_t;

	rx_state_t state;

	// Handshake FSM
	always_ff @(posedge clk_usb or posedge rst_usb) begin
		if (rst_usb) begin
			state <= RX_IDLE;
			wr_en <= 1'b0;
		end else begin
			// Write strobe lasts a single cycle
			wr_en <= 1'b0;
			case (state)
				RX_IDLE: begin
					// Back-pressure: no ack while the FIFO is full
					if (in_req && !full) begin
						state <= RX_ACK;
						wr_en <= 1'b1;
					end
				end
				RX_ACK: begin
					if (!in_req)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Byte capture, data held stable by the agent while in_req is high
	always_ff @(posedge clk_usb) begin
		if (state == RX_IDLE && in_req && !full) begin
			wr_byte.data <= in_data;
			wr_byte.last <= in_last;
		end
	end

	assign in_ack = (state == RX_ACK);

endmodule

// File: fifo/usb_byte_fifo.sv
/*
 * Packet byte FIFO
 *
 * Synchronous circular buffer with first-word fall-through reads.
 * Pointers carry one extra wrap bit so that full and empty decode
 * directly from them. Simultaneous write and read are both taken.
 */

`timescale 1ns/1ns

module usb_byte_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                   clk_usb,
	input  logic                   rst_usb,
	input  logic                   wr_en,
	input  usb_crc_pkg::usb_byte_t wr_byte,
	output logic                   full,
	input  logic                   rd_en,
	output usb_crc_pkg::usb_byte_t rd_byte,
	output logic                   empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	// ----------------------------------------
	// Storage and pointers
	// ----------------------------------------

	usb_crc_pkg::usb_byte_t mem [FIFO_DEPTH];

	logic [AW:0]   wr_ptr;
	logic [AW:0]   rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk_usb or posedge rst_usb) begin
		if (rst_usb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_usb) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_byte;
	end

	// ----------------------------------------
	// Flags and read port
	// ----------------------------------------

	// Same address, wrap bits differ when the buffer is full
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);

	// Head entry shows without a read strobe
	assign rd_byte = mem[rd_ptr[AW-1:0]];

endmodule

// File: crc/usb_crc16_chk.sv
/*
 * USB data CRC16 checker
 *
 * Pops bytes from the FIFO, runs a bytewise reflected CRC16 and a
 * byte count per packet, and hands the inverted CRC and the length
 * out over a four-phase req/ack channel after each last byte.
 */

`timescale 1ns/1ns

module usb_crc16_chk (
	input  logic                   clk_usb,
	input  logic                   rst_usb,
	input  logic                   empty,
	input  usb_crc_pkg::usb_byte_t rd_byte,
	output logic                   rd_en,
	output logic                   res_req,
	input  logic                   res_ack,
	output usb_crc_pkg::usb_crc_t  res_crc,
	output usb_crc_pkg::usb_len_t  res_len
);

	typedef enum logic [1:0] {
		CK_RUN,
		CK_REQ,
		CK_WAIT
	} ck_state_t;

	ck_state_t             state;
	usb_crc_pkg::usb_crc_t crc;
	usb_crc_pkg::usb_crc_t crc_nxt;
	usb_crc_pkg::usb_len_t len_cnt;

	// LSB-first CRC update over one byte
	function automatic usb_crc_pkg::usb_crc_t crc16_byte(
		input usb_crc_pkg::usb_crc_t c_in,
		input logic [7:0]            d
	);
		usb_crc_pkg::usb_crc_t c;
		c = c_in ^ {8'h00, d};
		for (int i = 0; i < 8; i++) begin
			if (c[0])
				c = (c >> 1) ^ usb_crc_pkg::CRC_POLY_REFL;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	assign crc_nxt = crc16_byte(crc, rd_byte.data);

	// Pop only while no result is outstanding
	assign rd_en = (state == CK_RUN) && !empty;

	// ----------------------------------------
	// Accumulate and report
	// ----------------------------------------

	always_ff @(posedge clk_usb or posedge rst_usb) begin
		if (rst_usb) begin
			state   <= CK_RUN;
			crc     <= usb_crc_pkg::CRC_INIT;
			len_cnt <= '0;
		end else begin
			case (state)
				CK_RUN: begin
					if (rd_en) begin
						crc     <= crc_nxt;
						len_cnt <= len_cnt + 10'd1;
						if (rd_byte.last) begin
							// Fresh seed for the next packet
							crc     <= usb_crc_pkg::CRC_INIT;
							len_cnt <= '0;
							state   <= CK_REQ;
						end
					end
				end
				CK_REQ: begin
					if (res_ack)
						state <= CK_WAIT;
				end
				CK_WAIT: begin
					if (!res_ack)
						state <= CK_RUN;
				end
				default: state <= CK_RUN;
			endcase
		end
	end

	// Result values held until the next last byte
	always_ff @(posedge clk_usb) begin
		if (rd_en && rd_byte.last) begin
			res_crc <= ~crc_nxt;
			res_len <= len_cnt + 10'd1;
		end
	end

	assign res_req = (state == CK_REQ);

endmodule

// File: verilog/usb_crc_top.sv
/*
 * USB CRC subsystem top
 *
 * Reset sequencer, input receiver, byte FIFO and CRC16 checker,
 * all on clk_usb behind the stretched PLL-lock reset.
 */

`timescale 1ns/1ns

module usb_crc_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                  clk_usb,
	input  logic                  pll_lock,
	input  logic                  in_req,
	input  logic [7:0]            in_data,
	input  logic                  in_last,
	output logic                  in_ack,
	output logic                  res_req,
	input  logic                  res_ack,
	output usb_crc_pkg::usb_crc_t res_crc,
	output usb_crc_pkg::usb_len_t res_len
);

	// ----------------------------------------
	// Internal wiring
	// ----------------------------------------

	logic                   rst_usb;
	logic                   wr_en;
	logic                   full;
	logic                   rd_en;
	logic                   empty;
	usb_crc_pkg::usb_byte_t wr_byte;
	usb_crc_pkg::usb_byte_t rd_byte;

	usb_rst_seq rst_seq_i (
		.clk_usb  (clk_usb),
		.pll_lock (pll_lock),
		.rst_usb  (rst_usb)
	);

	usb_byte_rx byte_rx_i (
		.clk_usb (clk_usb),
		.rst_usb (rst_usb),
		.in_req  (in_req),
		.in_data (in_data),
		.in_last (in_last),
		.in_ack  (in_ack),
		.full    (full),
		.wr_en   (wr_en),
		.wr_byte (wr_byte)
	);

	usb_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) byte_fifo_i (
		.clk_usb (clk_usb),
		.rst_usb (rst_usb),
		.wr_en   (wr_en),
		.wr_byte (wr_byte),
		.full    (full),
		.rd_en   (rd_en),
		.rd_byte (rd_byte),
		.empty   (empty)
	);

	usb_crc16_chk crc_chk_i (
		.clk_usb (clk_usb),
		.rst_usb (rst_usb),
		.empty   (empty),
		.rd_byte (rd_byte),
		.rd_en   (rd_en),
		.res_req (res_req),
		.res_ack (res_ack),
		.res_crc (res_crc),
		.res_len (res_len)
	);

endmodule

// File: dv/tb_clk_gen.sv
/*
 * Testbench clock and PLL lock model
 *
 * Drives clk_usb with an 8 ns period. pll_lock stays low for four
 * cycles at start and again after each lock_drop pulse.
 */

`timescale 1ns/1ns

module tb_clk_gen (
	input  logic lock_drop,
	output logic clk_usb,
	output logic pll_lock
);

	initial begin
		clk_usb = 1'b0;
		forever #4 clk_usb = ~clk_usb;
	end

	// Lock lost on a sampled lock_drop, regained four edges later
	initial begin
		pll_lock = 1'b0;
		forever begin
			repeat (4) @(posedge clk_usb);
			pll_lock <= 1'b1;
			do @(posedge clk_usb); while (!lock_drop);
			pll_lock <= 1'b0;
		end
	end

endmodule

// File: dv/usb_crc_tb.sv
/*
 * USB CRC subsystem testbench
 *
 * Checks reset release timing, known and random packets, result
 * back-pressure and a reset in the middle of a packet. Expected CRC
 * values come from a bitwise reference model of the USB data CRC16.
 */

`timescale 1ns/1ns

module usb_crc_tb;

	typedef logic [7:0] byte_q_t [$];

	localparam int unsigned N_RAND   = 200;
	localparam int unsigned HELD_LEN = 4;
	localparam int unsigned POST_LEN = 8;

	logic                  clk_usb;
	logic                  pll_lock;
	logic                  lock_drop;
	logic                  hold_ack;
	logic                  in_req;
	logic [7:0]            in_data;
	logic                  in_last;
	logic                  in_ack;
	logic                  res_req;
	logic                  res_ack;
	usb_crc_pkg::usb_crc_t res_crc;
	usb_crc_pkg::usb_len_t res_len;

	usb_crc_pkg::usb_crc_t exp_crc_q [$];
	usb_crc_pkg::usb_len_t exp_len_q [$];

	tb_clk_gen clk_gen_i (
		.lock_drop (lock_drop),
		.clk_usb   (clk_usb),
		.pll_lock  (pll_lock)
	);

	usb_crc_top #(
		.FIFO_DEPTH (16)
	) dut_i (
		.clk_usb  (clk_usb),
		.pll_lock (pll_lock),
		.in_req   (in_req),
		.in_data  (in_data),
		.in_last  (in_last),
		.in_ack   (in_ack),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_crc  (res_crc),
		.res_len  (res_len)
	);

	// ----------------------------------------
	// Reference model and checks
	// ----------------------------------------

	// One bit at a time, LSB first, inverted at the end
	function automatic usb_crc_pkg::usb_crc_t crc16_ref(input byte_q_t pkt);
		usb_crc_pkg::usb_crc_t crc;
		logic                  fb;
		crc = usb_crc_pkg::CRC_INIT;
		foreach (pkt[i]) begin
			for (int b = 0; b < 8; b++) begin
				fb  = crc[0] ^ pkt[i][b];
				crc = crc >> 1;
				if (fb)
					crc = crc ^ usb_crc_pkg::CRC_POLY_REFL;
			end
		end
		return ~crc;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_crc(input string sig, input usb_crc_pkg::usb_crc_t got,
		input usb_crc_pkg::usb_crc_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got 0x%04h expected 0x%04h", sig, got, exp));
	endtask

	task automatic check_len(input string sig, input usb_crc_pkg::usb_len_t got,
		input usb_crc_pkg::usb_len_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got 0x%03h expected 0x%03h", sig, got, exp));
	endtask

	task automatic watchdog(input int unsigned cycles);
		repeat (cycles) @(posedge clk_usb);
		report_failure($sformatf("timeout: run did not finish within %0d cycles", cycles));
	endtask

	// ----------------------------------------
	// Input agent
	// ----------------------------------------

	task automatic wait_ack(input logic level);
		do @(negedge clk_usb); while (in_ack !== level);
	endtask

	task automatic send_byte(input logic [7:0] data, input logic last);
		repeat ($urandom_range(3, 0)) @(posedge clk_usb);
		@(posedge clk_usb);
		in_data <= data;
		in_last <= last;
		in_req  <= 1'b1;
		wait_ack(1'b1);
		repeat ($urandom_range(3, 0)) @(posedge clk_usb);
		@(posedge clk_usb);
		in_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic send_packet(input byte_q_t pkt);
		exp_crc_q.push_back(crc16_ref(pkt));
		exp_len_q.push_back(usb_crc_pkg::usb_len_t'(pkt.size()));
		foreach (pkt[i])
			send_byte(pkt[i], i == pkt.size() - 1);
	endtask

	// Ack due on the 9th edge after lock with in_req held from the 1st
	task automatic check_reset_release(input logic [7:0] data);
		byte_q_t pkt;
		pkt.push_back(data);
		exp_crc_q.push_back(crc16_ref(pkt));
		exp_len_q.push_back(10'd1);
		do @(negedge clk_usb); while (pll_lock !== 1'b1);
		@(posedge clk_usb);
		in_data <= data;
		in_last <= 1'b1;
		in_req  <= 1'b1;
		repeat (8) begin
			@(negedge clk_usb);
			if (in_ack !== 1'b0)
				report_failure("in_ack rose before the domain reset was released");
		end
		@(negedge clk_usb);
		if (in_ack !== 1'b1)
			report_failure("in_ack did not rise one cycle after reset release");
		@(posedge clk_usb);
		in_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic drain_results(input int unsigned cycles);
		repeat (cycles) begin
			if (exp_crc_q.size() == 0)
				break;
			@(posedge clk_usb);
		end
	endtask

	// Result left pending and five bytes without last before lock is lost
	task automatic reset_mid_packet();
		byte_q_t pkt;
		hold_ack = 1'b1;
		repeat (HELD_LEN) pkt.push_back(8'($urandom_range(255, 0)));
		send_packet(pkt);
		do @(negedge clk_usb); while (res_req !== 1'b1);
		repeat (5) send_byte(8'($urandom_range(255, 0)), 1'b0);
		@(posedge clk_usb);
		in_data   <= 8'($urandom_range(255, 0));
		in_last   <= 1'b0;
		in_req    <= 1'b1;
		lock_drop <= 1'b1;
		@(posedge clk_usb);
		lock_drop <= 1'b0;
		@(negedge clk_usb);
		if (pll_lock !== 1'b0)
			report_failure("pll_lock did not drop on request");
		if (in_ack !== 1'b0 || res_req !== 1'b0)
			report_failure("in_ack or res_req stayed high while in reset");
		hold_ack = 1'b0;
		@(posedge clk_usb);
		in_req <= 1'b0;
	endtask

	// ----------------------------------------
	// Result side with every 16th ack delayed by 100 cycles
	// ----------------------------------------

	initial begin : compare_results
		int unsigned n_res;
		n_res   = 0;
		res_ack = 1'b0;
		forever begin
			do @(negedge clk_usb); while (res_req !== 1'b1);
			if (exp_crc_q.size() == 0)
				report_failure("result arrived with no packet outstanding");
			check_crc("res_crc", res_crc, exp_crc_q[0]);
			check_len("res_len", res_len, exp_len_q[0]);
			// Result kept pending across the lock drop
			while (hold_ack)
				@(posedge clk_usb);
			if (n_res % 16 == 7)
				repeat (100) @(posedge clk_usb);
			else
				repeat ($urandom_range(3, 0)) @(posedge clk_usb);
			@(posedge clk_usb);
			res_ack <= 1'b1;
			do @(negedge clk_usb); while (res_req !== 1'b0);
			repeat ($urandom_range(3, 0)) @(posedge clk_usb);
			@(posedge clk_usb);
			res_ack <= 1'b0;
			void'(exp_crc_q.pop_front());
			void'(exp_len_q.pop_front());
			n_res++;
		end
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin : main_seq
		byte_q_t     pkt;
		int unsigned pkt_len [N_RAND];
		int unsigned total;
		void'($urandom(32'hc615d259));
		in_req    = 1'b0;
		in_data   = 8'h00;
		in_last   = 1'b0;
		lock_drop = 1'b0;
		hold_ack  = 1'b0;

		// Known vectors, held and partial packets and post-reset traffic
		total = 6 + HELD_LEN + 6 + 1 + POST_LEN;
		foreach (pkt_len[i]) begin
			pkt_len[i] = $urandom_range(64, 1);
			total += pkt_len[i];
		end
		fork
			watchdog(64 * total + 2000);
		join_none

		check_reset_release(8'h00);
		pkt.push_back(8'h01);
		send_packet(pkt);
		pkt.delete();
		for (int i = 0; i < 4; i++)
			pkt.push_back(8'(i));
		send_packet(pkt);

		for (int p = 0; p < N_RAND; p++) begin
			pkt.delete();
			repeat (pkt_len[p]) pkt.push_back(8'($urandom_range(255, 0)));
			send_packet(pkt);
		end

		drain_results(1000);
		reset_mid_packet();
		check_reset_release(8'hA5);
		pkt.delete();
		repeat (POST_LEN) pkt.push_back(8'($urandom_range(255, 0)));
		send_packet(pkt);

		drain_results(1000);
		if (exp_crc_q.size() != 0) begin
			report_failure("not every packet produced a result");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: usb_crc_top.f
common/usb_crc_pkg.sv
verilog/usb_rst_seq.sv
verilog/usb_byte_rx.sv
fifo/usb_byte_fifo.sv
crc/usb_crc16_chk.sv
verilog/usb_crc_top.sv
dv/tb_clk_gen.sv
dv/usb_crc_tb.sv

// File: Makefile
# Verilator build and run for the USB CRC subsystem

VERILATOR ?= verilator
TOP       ?= usb_crc_tb
FILELIST  ?= usb_crc_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
